//--- tb.f
+incdir+tb
logic/net_pkg.sv
logic/phy_pkg.sv
logic/frame_if.sv
logic/nibble_if.sv
logic/frame_decode.sv
logic/nibble_execute.sv
logic/fcs_result.sv
logic/udp_tx_top.sv
tb/tb_udp_tx.sv

//--- Makefile
TOP := tb_udp_tx

.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --timescale 1ns/1ps --top-module $(TOP) \
		-f tb.f -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- tb/udp_tx_model.svh
// Expected wire image of one frame, built octet by octet from the protocol rules

logic [7:0] frame_bytes[$];
nibble_t    exp_q[$];

// Append a field of n octets, most significant octet first
function automatic void push_field(input logic [63:0] value, input int n);
    for (int i = n - 1; i >= 0; i--) begin
        frame_bytes.push_back(value[8*i +: 8]);
    end
endfunction

// Ones' complement sum of the ten IPv4 header words, carries folded back in
function automatic logic [15:0] ip_checksum(input int first);
    logic [31:0] sum;
    sum = '0;
    for (int k = 0; k < 10; k++) begin
        sum = sum + {16'h0000, frame_bytes[first + 2*k], frame_bytes[first + 2*k + 1]};
    end
    while (sum[31:16] != 16'h0000) begin
        sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
    end
    return ~sum[15:0];
endfunction

function automatic void build_frame(input logic [47:0] dmac, input logic [47:0] smac,
                                    input logic [31:0] sip, input logic [31:0] dip,
                                    input logic [15:0] sport, input logic [15:0] dport,
                                    input logic [8*DATA_BYTES-1:0] data);
    logic [15:0] csum;
    logic [31:0] crc;
    frame_bytes.delete();
    exp_q.delete();
    // Ethernet II
    push_field(64'(dmac), 6);
    push_field(64'(smac), 6);
    push_field(64'(ETHER_TYPE_IPV4), 2);
    // IPv4, checksum field zero while summing
    push_field(64'({IP_VERSION, IP_IHL}), 1);
    push_field(64'(IP_TOS), 1);
    push_field(64'(IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES), 2);
    // Identification, flags and offset all zero
    push_field(64'h0, 4);
    push_field(64'(IP_TTL), 1);
    push_field(64'(IP_PROTO_UDP), 1);
    push_field(64'h0, 2);
    push_field(64'(sip), 4);
    push_field(64'(dip), 4);
    csum = ip_checksum(14);
    // Checksum lives at octets 10 and 11 of the IP header
    frame_bytes[24] = csum[15:8];
    frame_bytes[25] = csum[7:0];
    // UDP with zero checksum
    push_field(64'(sport), 2);
    push_field(64'(dport), 2);
    push_field(64'(UDP_HEADER_BYTES + DATA_BYTES), 2);
    push_field(64'h0, 2);
    // First payload octet is the top byte of the bus
    for (int k = DATA_BYTES - 1; k >= 0; k--) begin
        frame_bytes.push_back(data[8*k +: 8]);
    end
    // Bitwise reflected CRC-32, each octet bit 0 first
    crc = 32'hFFFFFFFF;
    foreach (frame_bytes[i]) begin
        for (int b = 0; b < 8; b++) begin
            if (crc[0] ^ frame_bytes[i][b]) begin
                crc = (crc >> 1) ^ 32'hEDB88320;
            end else begin
                crc = crc >> 1;
            end
        end
    end
    crc = ~crc;
    // Seven 0x55 octets and the SFD, then the octets low nibble first
    repeat (15) exp_q.push_back(4'h5);
    exp_q.push_back(4'hD);
    foreach (frame_bytes[i]) begin
        exp_q.push_back(frame_bytes[i][3:0]);
        exp_q.push_back(frame_bytes[i][7:4]);
    end
    for (int k = 0; k < 8; k++) begin
        exp_q.push_back(crc[4*k +: 4]);
    end
endfunction

//--- tb/tb_udp_tx.sv
`timescale 1ns/1ps

module tb_udp_tx import net_pkg::*, phy_pkg::*;;

    localparam int DATA_BYTES  = 8;
    localparam int DIVIDER     = 4;
    localparam int FRAMES      = 10;
    // Ticks with tx_en high per frame
    localparam int FRAME_TICKS = PREAMBLE_NIBBLES + 2 * (HEADER_BYTES + DATA_BYTES) + FCS_NIBBLES;
    // Every frame with its gap and send wait, doubled for margin
    localparam int TIMEOUT_CLOCKS = 2 * (FRAMES + 2) * (FRAME_TICKS + GAP_NIBBLES + 8) * DIVIDER;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                    clk;
    logic                    reset;
    logic                    send;
    logic [47:0]             src_mac;
    logic [47:0]             dest_mac;
    logic [31:0]             src_ip;
    logic [31:0]             dest_ip;
    logic [15:0]             src_port;
    logic [15:0]             dest_port;
    logic [8*DATA_BYTES-1:0] payload;
    logic                    ready;
    logic                    tx_en;
    nibble_t                 tx_d;

    logic [31:0] lfsr = 32'd63;
    nibble_t     rx_q[$];
    logic        tx_en_prev = 1'b0;
    int          cycles = 0;
    int          en_clocks = 0;
    int          gap_clocks = 0;
    int          bursts = 0;
    int          checks = 0;
    int          errors = 0;
    int          tests = 0;
    int          failed_tests = 0;
    int          errors_before = 0;

    `include "udp_tx_model.svh"

    udp_tx_top #(.DATA_BYTES(DATA_BYTES), .DIVIDER(DIVIDER)) i_udp_tx_top (
        .clk       (clk),
        .reset     (reset),
        .send      (send),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .payload   (payload),
        .ready     (ready),
        .tx_en     (tx_en),
        .tx_d      (tx_d)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v[i] = lfsr[0];
        end
        return v;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic randomize_inputs();
        src_mac   = 48'(take_bits(48));
        dest_mac  = 48'(take_bits(48));
        src_ip    = 32'(take_bits(32));
        dest_ip   = 32'(take_bits(32));
        src_port  = 16'(take_bits(16));
        dest_port = 16'(take_bits(16));
        for (int k = 0; k < DATA_BYTES; k++) begin
            payload[8*k +: 8] = 8'(take_bits(8));
        end
    endtask

    task automatic check_nibble(input string name, input nibble_t got, input nibble_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != errors_before) begin
            failed_tests++;
            $display("test %0d %s: failed", tests, name);
        end else begin
            $display("test %0d %s: passed", tests, name);
        end
        errors_before = errors;
    endtask

    // Watchdog and capture, sampled mid-cycle where outputs are settled
    always @(negedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CLOCKS) begin
            $display("Timeout: the run did not finish within %0d clocks", TIMEOUT_CLOCKS);
            $display("TEST FAILED");
            $finish;
        end else if (!reset) begin
            if (tx_en && !tx_en_prev) begin
                bursts++;
            end
            if (tx_en) begin
                // One new nibble every DIVIDER clocks from the burst start
                if (en_clocks % DIVIDER == 0) begin
                    rx_q.push_back(tx_d);
                end
                en_clocks++;
            end else if (en_clocks > 0 && !ready) begin
                gap_clocks++;
            end
            tx_en_prev = tx_en;
        end
    end

    initial begin
        reset = 1'b1;
        // Held high through reset, must not count as an edge
        send  = 1'b1;
        src_mac   = '0;
        dest_mac  = '0;
        src_ip    = '0;
        dest_ip   = '0;
        src_port  = '0;
        dest_port = '0;
        payload   = '0;
        repeat (5) @(posedge clk);
        #10;
        reset = 1'b0;
        repeat (8 * DIVIDER) next_cycle();
        @(negedge clk);
        check_flag("ready", ready, 1'b1);
        check_flag("tx_en", tx_en, 1'b0);
        check_count("bursts", bursts, 0);
        report_test("reset with send held high");
        next_cycle();
        send = 1'b0;

        for (int f = 0; f < FRAMES; f++) begin
            randomize_inputs();
            build_frame(dest_mac, src_mac, src_ip, dest_ip, src_port, dest_port, payload);
            rx_q.delete();
            en_clocks  = 0;
            gap_clocks = 0;
            // Random idle time, send low for at least one clock
            repeat (1 + int'(take_bits(3))) next_cycle();
            send = 1'b1;
            // Edge sampled at the next clock, ready low one clock later
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_flag("ready", ready, 1'b0);
            next_cycle();
            // Inputs move after the edge, frame must keep the latched values
            payload  = 64'(take_bits(64));
            src_port = 16'(take_bits(16));
            send     = 1'b0;
            repeat (4) next_cycle();
            // Edge while busy is ignored
            send = 1'b1;
            while (!ready) @(negedge clk);
            next_cycle();
            check_count("tx_en clocks", en_clocks, FRAME_TICKS * DIVIDER);
            check_count("gap ticks", gap_clocks / DIVIDER, GAP_NIBBLES);
            check_count("nibbles", rx_q.size(), exp_q.size());
            for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
                check_nibble($sformatf("tx_d[%0d]", i), rx_q[i], exp_q[i]);
            end
            send = 1'b0;
            report_test($sformatf("frame %0d", f));
        end

        repeat (8 * DIVIDER) next_cycle();
        check_count("bursts", bursts, FRAMES);
        check_flag("tx_en", tx_en, 1'b0);
        report_test("no extra frames");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- logic/udp_tx_top.sv
`timescale 1ns/1ps

module udp_tx_top import phy_pkg::*; #(
    // Payload octets, 1 to MAX_DATA_BYTES
    parameter int DATA_BYTES = 8,
    // System clocks per MII nibble, at least 2
    parameter int DIVIDER    = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    send,
    input  logic [47:0]             src_mac,
    input  logic [47:0]             dest_mac,
    input  logic [31:0]             src_ip,
    input  logic [31:0]             dest_ip,
    input  logic [15:0]             src_port,
    input  logic [15:0]             dest_port,
    input  logic [8*DATA_BYTES-1:0] payload,
    output logic                    ready,
    output logic                    tx_en,
    output nibble_t                 tx_d
);

    frame_if #(.DATA_BYTES(DATA_BYTES)) frame_bus ();
    nibble_if nibble_bus ();

    frame_decode #(.DATA_BYTES(DATA_BYTES)) u_decode (
        .clk       (clk),
        .reset     (reset),
        .send      (send),
        .src_mac   (src_mac),
        .dest_mac  (dest_mac),
        .src_ip    (src_ip),
        .dest_ip   (dest_ip),
        .src_port  (src_port),
        .dest_port (dest_port),
        .payload   (payload),
        .frame     (frame_bus.decode),
        .ready     (ready)
    );

    nibble_execute #(.DATA_BYTES(DATA_BYTES), .DIVIDER(DIVIDER)) u_execute (
        .clk    (clk),
        .reset  (reset),
        .frame  (frame_bus.execute),
        .stream (nibble_bus.execute)
    );

    fcs_result u_result (
        .clk    (clk),
        .reset  (reset),
        .stream (nibble_bus.result),
        .frame  (frame_bus.result),
        .tx_en  (tx_en),
        .tx_d   (tx_d)
    );

endmodule

//--- logic/fcs_result.sv
`timescale 1ns/1ps

module fcs_result import phy_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    nibble_if.result stream,
    frame_if.result  frame,
    output logic     tx_en,
    output nibble_t  tx_d
);

    localparam int CNT_W = $clog2(GAP_NIBBLES + 1);

    typedef enum logic [1:0] {
        S_DATA,
        S_FCS,
        S_GAP
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] cnt;
    logic [31:0]      crc;
    // Stream fields changed in the previous clock
    logic             tick_q;

    // Reflected CRC-32 over one nibble, bit 0 first as on the wire
    function automatic logic [31:0] crc_nibble(input logic [31:0] crc_in, input nibble_t data);
        logic [31:0] c;
        c = crc_in;
        for (int b = 0; b < 4; b++) begin
            if (c[0] ^ data[b]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= S_DATA;
            cnt        <= '0;
            crc        <= CRC_INIT;
            tick_q     <= 1'b0;
            tx_en      <= 1'b0;
            frame.done <= 1'b0;
        end else begin
            tick_q     <= stream.tick;
            frame.done <= 1'b0;
            if (tick_q) begin
                case (state)
                    S_DATA: begin
                        tx_en <= stream.valid;
                        if (stream.valid) begin
                            tx_d <= stream.nibble;
                        end
                        if (stream.valid && stream.crc_en) begin
                            crc <= crc_nibble(crc, stream.nibble);
                        end
                        if (stream.last) begin
                            state <= S_FCS;
                            cnt   <= '0;
                        end
                    end
                    S_FCS: begin
                        if (cnt == CNT_W'(FCS_NIBBLES)) begin
                            // First gap tick
                            tx_en <= 1'b0;
                            state <= S_GAP;
                            cnt   <= CNT_W'(1);
                        end else begin
                            // Complemented CRC, least significant nibble first
                            tx_d <= ~crc[3:0];
                            crc  <= crc >> 4;
                            cnt  <= cnt + 1'b1;
                        end
                    end
                    S_GAP: begin
                        if (cnt == CNT_W'(GAP_NIBBLES)) begin
                            frame.done <= 1'b1;
                            crc        <= CRC_INIT;
                            state      <= S_DATA;
                            cnt        <= '0;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                    default: state <= S_DATA;
                endcase
            end
        end
    end

    // Line stays idle and the serializer stays quiet for the whole gap
    a_gap_idle: assert property (@(posedge clk) disable iff (reset)
        (state == S_GAP) |-> (!tx_en && !stream.valid))
        else $error("activity during interframe gap");

endmodule

//--- logic/nibble_execute.sv
`timescale 1ns/1ps

module nibble_execute import net_pkg::*, phy_pkg::*; #(
    parameter int DATA_BYTES = 8,
    parameter int DIVIDER    = 4
) (
    input  logic     clk,
    input  logic     reset,
    frame_if.execute frame,
    nibble_if.execute stream
);

    localparam int FRAME_BYTES   = HEADER_BYTES + DATA_BYTES;
    localparam int TOTAL_NIBBLES = PREAMBLE_NIBBLES + 2 * FRAME_BYTES;
    localparam int IDX_W         = $clog2(TOTAL_NIBBLES);
    localparam int DIV_W         = $clog2(DIVIDER);

    logic [DIV_W-1:0]         div_cnt;
    logic                     busy;
    logic [IDX_W-1:0]         idx;
    logic [8*FRAME_BYTES-1:0] frame_bits;
    nibble_t                  data_nibble;

    // Free-running divider, stands in for the PHY transmit clock
    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt     <= '0;
            stream.tick <= 1'b0;
        end else if (div_cnt == DIV_W'(DIVIDER - 1)) begin
            div_cnt     <= '0;
            stream.tick <= 1'b1;
        end else begin
            div_cnt     <= div_cnt + 1'b1;
            stream.tick <= 1'b0;
        end
    end

    assign frame_bits = {frame.headers, frame.payload};

    // Octet idx/2 after the SFD, low nibble on even counts
    always_comb begin
        int unsigned data_idx;
        int unsigned bit_pos;
        data_idx = 0;
        if (idx >= IDX_W'(PREAMBLE_NIBBLES)) begin
            data_idx = idx - PREAMBLE_NIBBLES;
        end
        bit_pos = 8 * (FRAME_BYTES - 1 - data_idx / 2) + 4 * (data_idx % 2);
        data_nibble = frame_bits[bit_pos +: 4];
    end

    // Serializer, one nibble per tick
    always_ff @(posedge clk) begin
        if (reset) begin
            busy          <= 1'b0;
            idx           <= '0;
            stream.valid  <= 1'b0;
            stream.crc_en <= 1'b0;
            stream.last   <= 1'b0;
        end else begin
            if (frame.load) begin
                busy <= 1'b1;
                idx  <= '0;
            end
            if (stream.tick && busy) begin
                stream.valid  <= 1'b1;
                stream.crc_en <= idx >= IDX_W'(PREAMBLE_NIBBLES);
                stream.last   <= idx == IDX_W'(TOTAL_NIBBLES - 1);
                if (idx < IDX_W'(PREAMBLE_NIBBLES - 1)) begin
                    stream.nibble <= PREAMBLE_NIBBLE;
                end else if (idx == IDX_W'(PREAMBLE_NIBBLES - 1)) begin
                    stream.nibble <= SFD_NIBBLE;
                end else begin
                    stream.nibble <= data_nibble;
                end
                idx <= idx + 1'b1;
                if (idx == IDX_W'(TOTAL_NIBBLES - 1)) begin
                    busy <= 1'b0;
                end
            end else if (stream.tick) begin
                // Idle tick, stream goes quiet
                stream.valid  <= 1'b0;
                stream.crc_en <= 1'b0;
                stream.last   <= 1'b0;
            end
        end
    end

    a_tick_single: assert property (@(posedge clk) disable iff (reset)
        stream.tick |=> !stream.tick)
        else $error("tick high for two clocks");

    a_last_valid: assert property (@(posedge clk) disable iff (reset)
        stream.last |-> stream.valid)
        else $error("last without valid");

endmodule

//--- logic/frame_decode.sv
`timescale 1ns/1ps

module frame_decode import net_pkg::*; #(
    parameter int DATA_BYTES = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    send,
    input  logic [47:0]             src_mac,
    input  logic [47:0]             dest_mac,
    input  logic [31:0]             src_ip,
    input  logic [31:0]             dest_ip,
    input  logic [15:0]             src_port,
    input  logic [15:0]             dest_port,
    input  logic [8*DATA_BYTES-1:0] payload,
    frame_if.decode                 frame,
    output logic                    ready
);

    logic           send_prev;
    logic           accept;
    ipv4_header_t   ip_hdr;
    logic [19:0]    word_sum;
    logic [16:0]    fold_sum;
    frame_headers_t hdr_next;

    // Rising edge of send, taken only while idle
    assign accept = send && !send_prev && ready && !frame.load;

    // IPv4 header with the checksum computed over the zero-checksum image
    always_comb begin
        ip_hdr.version         = IP_VERSION;
        ip_hdr.ihl             = IP_IHL;
        ip_hdr.type_of_service = IP_TOS;
        ip_hdr.total_length    = 16'(IP_HEADER_BYTES + UDP_HEADER_BYTES + DATA_BYTES);
        ip_hdr.identification  = IP_ID;
        ip_hdr.flags           = IP_FLAGS;
        ip_hdr.fragment_offset = IP_FRAG_OFFSET;
        ip_hdr.time_to_live    = IP_TTL;
        ip_hdr.protocol        = IP_PROTO_UDP;
        ip_hdr.header_checksum = '0;
        ip_hdr.src_ip          = src_ip;
        ip_hdr.dest_ip         = dest_ip;
        // Sum of the ten 16-bit words, at most 20 bits wide
        word_sum = '0;
        for (int k = 0; k < IP_HEADER_BYTES / 2; k++) begin
            word_sum = word_sum + 20'(ip_hdr[16*k +: 16]);
        end
        // Two end-around carry folds are always enough here
        fold_sum = 17'(word_sum[15:0]) + 17'(word_sum[19:16]);
        ip_hdr.header_checksum = ~(fold_sum[15:0] + 16'(fold_sum[16]));
    end

    always_comb begin
        hdr_next.eth.dest_mac   = dest_mac;
        hdr_next.eth.src_mac    = src_mac;
        hdr_next.eth.ether_type = ETHER_TYPE_IPV4;
        hdr_next.ip             = ip_hdr;
        hdr_next.udp.src_port   = src_port;
        hdr_next.udp.dest_port  = dest_port;
        hdr_next.udp.length     = 16'(UDP_HEADER_BYTES + DATA_BYTES);
        // UDP checksum is optional over IPv4
        hdr_next.udp.checksum   = '0;
    end

    // Edge detect, load strobe and ready handshake
    always_ff @(posedge clk) begin
        if (reset) begin
            // High so a send held through reset is no edge
            send_prev  <= 1'b1;
            frame.load <= 1'b0;
            ready      <= 1'b1;
        end else begin
            send_prev  <= send;
            frame.load <= accept;
            if (frame.load) begin
                ready <= 1'b0;
            end else if (frame.done) begin
                ready <= 1'b1;
            end
        end
    end

    // Frame contents stay put until the next accepted edge
    always_ff @(posedge clk) begin
        if (accept) begin
            frame.headers <= hdr_next;
            frame.payload <= payload;
        end
    end

    // A new frame never starts while one is in flight
    a_load_when_ready: assert property (@(posedge clk) disable iff (reset)
        !(frame.load && !ready))
        else $error("load while ready is low");

endmodule

//--- logic/nibble_if.sv
`timescale 1ns/1ps

interface nibble_if import phy_pkg::*;;

    // Pacing strobe, one clock in every DIVIDER
    logic    tick;
    logic    valid;
    nibble_t nibble;
    // Nibble is covered by the FCS
    logic    crc_en;
    // Final payload nibble
    logic    last;

    modport execute (output tick, output valid, output nibble, output crc_en, output last);

    modport result (input tick, input valid, input nibble, input crc_en, input last);

endinterface

//--- logic/frame_if.sv
`timescale 1ns/1ps

interface frame_if import net_pkg::*; #(
    parameter int DATA_BYTES = 8
);

    // Single-cycle start of a frame
    logic                    load;
    frame_headers_t          headers;
    // First payload octet on the wire sits in the top byte
    logic [8*DATA_BYTES-1:0] payload;
    // Single-cycle end of the interframe gap
    logic                    done;

    modport decode (output load, output headers, output payload, input done);

    modport execute (input load, input headers, input payload);

    modport result (output done);

endinterface

//--- logic/phy_pkg.sv
package phy_pkg;

    // One MII transmit symbol
    typedef logic [3:0] nibble_t;

    // Seven 0x55 octets and the 0xD5 SFD, low nibble first
    localparam int      PREAMBLE_NIBBLES = 16;
    localparam nibble_t PREAMBLE_NIBBLE  = 4'h5;
    localparam nibble_t SFD_NIBBLE       = 4'hD;

    localparam int FCS_NIBBLES = 8;
    // 12 octet interframe gap
    localparam int GAP_NIBBLES = 24;

    // Reflected form of 0x04C11DB7
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

endpackage

//--- logic/net_pkg.sv
package net_pkg;

    // Ethernet II header, 14 octets, fields in wire order from the top bit
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] ether_type;
    } eth_header_t;

    // IPv4 header without options, 20 octets, RFC 791 field order
    typedef struct packed {
        logic [3:0]  version;
        logic [3:0]  ihl;
        logic [7:0]  type_of_service;
        logic [15:0] total_length;
        logic [15:0] identification;
        logic [2:0]  flags;
        logic [12:0] fragment_offset;
        logic [7:0]  time_to_live;
        logic [7:0]  protocol;
        logic [15:0] header_checksum;
        logic [31:0] src_ip;
        logic [31:0] dest_ip;
    } ipv4_header_t;

    // UDP header, 8 octets, RFC 768
    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dest_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_header_t;

    // All three headers, first octet on the wire in the top byte
    typedef struct packed {
        eth_header_t  eth;
        ipv4_header_t ip;
        udp_header_t  udp;
    } frame_headers_t;

    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;
    localparam logic [3:0]  IP_VERSION      = 4'd4;
    // Five 32-bit words, no options
    localparam logic [3:0]  IP_IHL          = 4'd5;
    localparam logic [7:0]  IP_TOS          = 8'h0C;
    localparam logic [15:0] IP_ID           = 16'h0000;
    localparam logic [2:0]  IP_FLAGS        = 3'b000;
    localparam logic [12:0] IP_FRAG_OFFSET  = 13'd0;
    localparam logic [7:0]  IP_TTL          = 8'hFF;
    localparam logic [7:0]  IP_PROTO_UDP    = 8'h11;

    localparam int HEADER_BYTES     = 42;
    localparam int IP_HEADER_BYTES  = 20;
    localparam int UDP_HEADER_BYTES = 8;
    // 576 - 60 - 8, largest payload every host must accept
    localparam int MAX_DATA_BYTES   = 508;

endpackage
